/* design/xbridge_macros.svh */
/*
 * Build-time sizes of the lane bridge.
 * Include this header wherever a module or package sizes itself from the
 * data width, the lane count or the lane depth.
 */
`ifndef XBRIDGE_MACROS_SVH
`define XBRIDGE_MACROS_SVH

// Beat payload
`define XB_DATA_W        16                 // Data word bits

// Lane array
`define XB_LANES         4                  // Lanes in rotation
`define XB_DEPTH         6                  // Entries per lane, not a power of two
`define XB_ALMOST_LEVEL  (`XB_DEPTH - 1)    // Fill level where almost-full rises

// Lane pointer width is the address bits plus one wrap bit
`define XB_PTR_W         ($clog2(`XB_DEPTH) + 1)

`endif

/* design/stream_pkg.sv */
/*
 * Payload types that travel through the bridge.
 * A beat is one data word plus the flag marking the end of a packet.
 * Lanes store whole beats and never look inside them.
 */
`default_nettype none
`include "xbridge_macros.svh"

package stream_pkg;

    typedef logic [`XB_DATA_W-1:0] data_t;     // Data word

    // One beat as stored in a lane, 17 bits
    typedef struct packed {
        data_t data;                            // Word from the source
        logic  last;                            // Last beat of packet
    } beat_t;

endpackage

`default_nettype wire

/* design/cdc_pkg.sv */
/*
 * Types shared by both sides of the clock crossing.
 * Lane pointers and the lane rotation index and vectors live here,
 * apart from the payload they move.
 */
`default_nettype none
`include "xbridge_macros.svh"

package cdc_pkg;

    // Lane pointer in binary or gray form, address plus wrap bit
    typedef logic [`XB_PTR_W-1:0] ptr_t;

    typedef logic [$clog2(`XB_LANES)-1:0] lane_idx_t;    // Lane number

    // One bit per lane, for strobes and flags
    typedef logic [`XB_LANES-1:0] lane_vec_t;

endpackage

`default_nettype wire

/* design/lane_fifo.sv */
/*
 * One dual-clock FIFO lane of the bridge.
 * Gray pointers with a wrap bit cross through two-flop synchronizers.
 * Addresses wrap at DEPTH, so any depth works, not only powers of two.
 * rd_dout shows the head entry with no latency while rd_empty is low.
 */
`default_nettype none
`include "xbridge_macros.svh"

module lane_fifo #(
    parameter type payload_t    = logic,
    parameter int  DEPTH        = `XB_DEPTH,
    parameter int  ALMOST_LEVEL = `XB_ALMOST_LEVEL
) (
    // Write port
    input  wire           wr_clk,
    input  wire           wr_nreset,
    input  wire           wr_en,            // Push, ignored while full
    input  wire payload_t wr_din,
    output logic          wr_full,
    output logic          wr_almost_full,
    // Read port
    input  wire           rd_clk,
    input  wire           rd_nreset,
    input  wire           rd_en,            // Pop, ignored while empty
    output payload_t      rd_dout,          // Head entry
    output logic          rd_empty
);
    import cdc_pkg::*;

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;   // Memory address bits

    // Write domain
    ptr_t          wr_bin;
    ptr_t          wr_bin_nxt;
    ptr_t          wr_gray;
    ptr_t          rd_gray_meta;            // First sync stage
    ptr_t          rd_gray_sync;
    ptr_t          rd_bin_sync;
    ptr_t          wr_used;                 // Entries as seen by the writer
    logic [AW-1:0] wr_addr;
    logic          wr_push;

    // Read domain
    ptr_t          rd_bin;
    ptr_t          rd_bin_nxt;
    ptr_t          rd_gray;
    ptr_t          rd_gray_nxt;
    ptr_t          wr_gray_meta;
    ptr_t          wr_gray_sync;
    ptr_t          wr_bin_sync;
    ptr_t          rd_used;                 // Entries as seen by the reader
    logic [AW-1:0] rd_addr;
    logic          rd_pop;

    payload_t mem [DEPTH];

    function automatic ptr_t bin2gray(input ptr_t bin);
        return bin ^ (bin >> 1);
    endfunction

    function automatic ptr_t gray2bin(input ptr_t gray);
        ptr_t bin;
        bin[AW] = gray[AW];
        for (int k = AW - 1; k >= 0; k--) begin
            bin[k] = bin[k+1] ^ gray[k];
        end
        return bin;
    endfunction

    // Pointer type has to cover the address plus wrap bit
    if ($bits(ptr_t) != AW + 1) begin : g_ptr_w_check
        $error("lane_fifo pointer width does not match DEPTH");
    end

    // ####################################################################
    // Write side
    // ####################################################################

    assign wr_push     = wr_en & ~wr_full;
    assign wr_bin_nxt  = wr_bin + ptr_t'(wr_push);
    assign rd_bin_sync = gray2bin(rd_gray_sync);
    assign wr_used     = wr_bin - rd_bin_sync;      // Modulo pointer range

    always_ff @(posedge wr_clk or negedge wr_nreset) begin
        if (!wr_nreset) begin
            wr_bin         <= '0;
            wr_gray        <= '0;
            wr_addr        <= '0;
            wr_full        <= 1'b0;
            wr_almost_full <= 1'b0;
        end else begin
            wr_bin  <= wr_bin_nxt;
            wr_gray <= bin2gray(wr_bin_nxt);        // One bit changes per push
            if (wr_push) begin
                wr_addr <= (wr_addr == AW'(DEPTH - 1)) ? '0 : wr_addr + 1'b1;
            end
            // Flags include this edge's push
            wr_full        <= (wr_used + ptr_t'(wr_push)) >= DEPTH;
            wr_almost_full <= (wr_used + ptr_t'(wr_push)) >= ALMOST_LEVEL;
        end
    end

    // Read pointer into the write clock
    always_ff @(posedge wr_clk or negedge wr_nreset) begin
        if (!wr_nreset) begin
            rd_gray_meta <= '0;
            rd_gray_sync <= '0;
        end else begin
            rd_gray_meta <= rd_gray;
            rd_gray_sync <= rd_gray_meta;
        end
    end

    always_ff @(posedge wr_clk) begin
        if (wr_push) begin
            mem[wr_addr] <= wr_din;
        end
    end

    // ####################################################################
    // Read side
    // ####################################################################

    assign rd_pop      = rd_en & ~rd_empty;
    assign rd_bin_nxt  = rd_bin + ptr_t'(rd_pop);
    assign rd_gray_nxt = bin2gray(rd_bin_nxt);
    assign wr_bin_sync = gray2bin(wr_gray_sync);
    assign rd_used     = wr_bin_sync - rd_bin;

    always_ff @(posedge rd_clk or negedge rd_nreset) begin
        if (!rd_nreset) begin
            rd_bin   <= '0;
            rd_gray  <= '0;
            rd_addr  <= '0;
            rd_empty <= 1'b1;
        end else begin
            rd_bin  <= rd_bin_nxt;
            rd_gray <= rd_gray_nxt;
            if (rd_pop) begin
                rd_addr <= (rd_addr == AW'(DEPTH - 1)) ? '0 : rd_addr + 1'b1;
            end
            rd_empty <= (rd_gray_nxt == wr_gray_sync);  // Caught up with writer
        end
    end

    // Write pointer into the read clock
    always_ff @(posedge rd_clk or negedge rd_nreset) begin
        if (!rd_nreset) begin
            wr_gray_meta <= '0;
            wr_gray_sync <= '0;
        end else begin
            wr_gray_meta <= wr_gray;
            wr_gray_sync <= wr_gray_meta;
        end
    end

    assign rd_dout = mem[rd_addr];                 // Zero-latency head

    // A registered full that was low must still leave room at the push,
    // whatever the read pointer did in between
    assert property (@(posedge wr_clk) disable iff (!wr_nreset)
        wr_push |-> wr_used < DEPTH)
        else $error("Error %0t wr_used expected < %0d actual %0d", $time, DEPTH, wr_used);

    // Synchronized write pointer stays within one lane of the read pointer
    assert property (@(posedge rd_clk) disable iff (!rd_nreset)
        rd_used <= DEPTH)
        else $error("Error %0t rd_used expected <= %0d actual %0d", $time, DEPTH, rd_used);

endmodule

`default_nettype wire

/* design/lane_splitter.sv */
/*
 * Write-side rotation of the lane bridge.
 * Packs each word with its last flag and strobes the current lane.
 * The index moves on only when that lane took the beat, so a write
 * offered while full is simply dropped. Flags shown to the source are
 * those of the current lane.
 */
`default_nettype none
`include "xbridge_macros.svh"

module lane_splitter (
    input  wire                     wr_clk,
    input  wire                     wr_nreset,
    input  wire                     wr_en,
    input  wire stream_pkg::data_t  wr_data,
    input  wire                     wr_last,
    input  wire cdc_pkg::lane_vec_t lane_full,
    input  wire cdc_pkg::lane_vec_t lane_almost_full,
    output logic                    wr_full,
    output logic                    wr_almost_full,
    output cdc_pkg::lane_vec_t      lane_wr_en,        // One strobe per lane
    output stream_pkg::beat_t       wr_beat            // Shared by all lanes
);
    import cdc_pkg::*;

    lane_idx_t wr_idx;                                  // Lane for the next beat
    logic      wr_accept;

    assign wr_beat = '{data: wr_data, last: wr_last};

    // Source sees only the current lane
    assign wr_full        = lane_full[wr_idx];
    assign wr_almost_full = lane_almost_full[wr_idx];
    assign wr_accept      = wr_en & ~wr_full;

    // Raw strobe, the lane gates it with its own full
    always_comb begin
        lane_wr_en         = '0;
        lane_wr_en[wr_idx] = wr_en;
    end

    // ####################################################################
    // Rotation
    // ####################################################################

    always_ff @(posedge wr_clk or negedge wr_nreset) begin
        if (!wr_nreset) begin
            wr_idx <= '0;
        end else if (wr_accept) begin
            // Wrap after the last lane
            wr_idx <= (wr_idx == lane_idx_t'(`XB_LANES - 1)) ? '0 : wr_idx + 1'b1;
        end
    end

    assert property (@(posedge wr_clk) disable iff (!wr_nreset)
        $onehot0(lane_wr_en))
        else $error("Error %0t lane_wr_en expected onehot0 actual %b", $time, lane_wr_en);

endmodule

`default_nettype wire

/* design/lane_merger.sv */
/*
 * Read-side rotation of the lane bridge.
 * Shows the head beat and empty flag of the current lane and pops it
 * on an accepted read. Lanes are drained in the order the splitter
 * filled them, so beats leave in arrival order.
 */
`default_nettype none
`include "xbridge_macros.svh"

module lane_merger (
    input  wire                     rd_clk,
    input  wire                     rd_nreset,
    input  wire                     rd_en,
    input  wire cdc_pkg::lane_vec_t lane_empty,
    input  wire stream_pkg::beat_t  lane_dout [`XB_LANES],   // Head of each lane
    output logic                    rd_empty,
    output stream_pkg::data_t       rd_data,
    output logic                    rd_last,
    output cdc_pkg::lane_vec_t      lane_rd_en
);
    import cdc_pkg::*;

    lane_idx_t rd_idx;                                  // Lane holding the next beat
    logic      rd_accept;

    // Current lane's head, valid while not empty
    assign rd_empty  = lane_empty[rd_idx];
    assign rd_data   = lane_dout[rd_idx].data;
    assign rd_last   = lane_dout[rd_idx].last;
    assign rd_accept = rd_en & ~rd_empty;

    // Pop strobe only on an accepted read
    always_comb begin
        lane_rd_en         = '0;
        lane_rd_en[rd_idx] = rd_accept;
    end

    // ####################################################################
    // Rotation
    // ####################################################################

    always_ff @(posedge rd_clk or negedge rd_nreset) begin
        if (!rd_nreset) begin
            rd_idx <= '0;
        end else if (rd_accept) begin
            rd_idx <= (rd_idx == lane_idx_t'(`XB_LANES - 1)) ? '0 : rd_idx + 1'b1;
        end
    end

    assert property (@(posedge rd_clk) disable iff (!rd_nreset)
        $onehot0(lane_rd_en))
        else $error("Error %0t lane_rd_en expected onehot0 actual %b", $time, lane_rd_en);

endmodule

`default_nettype wire

/* design/xbridge_top.sv */
/*
 * Top level of the multi-lane clock-domain bridge.
 * Beats written in the wr_clk domain are spread over the lanes in
 * rotation and collected again in the rd_clk domain in the same order.
 * Write side uses wr_en with wr_full back-pressure, read side rd_en
 * while rd_empty is low.
 */
`default_nettype none
`include "xbridge_macros.svh"

module xbridge_top (
    // Write domain
    input  wire                    wr_clk,
    input  wire                    wr_nreset,
    input  wire stream_pkg::data_t wr_data,
    input  wire                    wr_last,
    input  wire                    wr_en,
    output wire                    wr_full,
    output wire                    wr_almost_full,
    // Read domain
    input  wire                    rd_clk,
    input  wire                    rd_nreset,
    input  wire                    rd_en,
    output wire                    rd_empty,
    output wire stream_pkg::data_t rd_data,
    output wire                    rd_last
);
    import stream_pkg::*;
    import cdc_pkg::*;

    wire lane_vec_t lane_wr_en;
    wire lane_vec_t lane_full;
    wire lane_vec_t lane_almost_full;
    wire lane_vec_t lane_rd_en;
    wire lane_vec_t lane_empty;
    wire beat_t     wr_beat;                        // Broadcast to all lanes
    wire beat_t     lane_dout [`XB_LANES];

    lane_splitter u_lane_splitter (
        .wr_clk           (wr_clk),
        .wr_nreset        (wr_nreset),
        .wr_en            (wr_en),
        .wr_data          (wr_data),
        .wr_last          (wr_last),
        .lane_full        (lane_full),
        .lane_almost_full (lane_almost_full),
        .wr_full          (wr_full),
        .wr_almost_full   (wr_almost_full),
        .lane_wr_en       (lane_wr_en),
        .wr_beat          (wr_beat)
    );

    // Identical lanes, each with its own pointer crossing
    for (genvar i = 0; i < `XB_LANES; i++) begin : g_lane
        lane_fifo #(
            .payload_t    (beat_t),
            .DEPTH        (`XB_DEPTH),
            .ALMOST_LEVEL (`XB_ALMOST_LEVEL)
        ) u_lane_fifo (
            .wr_clk         (wr_clk),
            .wr_nreset      (wr_nreset),
            .wr_en          (lane_wr_en[i]),
            .wr_din         (wr_beat),
            .wr_full        (lane_full[i]),
            .wr_almost_full (lane_almost_full[i]),
            .rd_clk         (rd_clk),
            .rd_nreset      (rd_nreset),
            .rd_en          (lane_rd_en[i]),
            .rd_dout        (lane_dout[i]),
            .rd_empty       (lane_empty[i])
        );
    end

    lane_merger u_lane_merger (
        .rd_clk     (rd_clk),
        .rd_nreset  (rd_nreset),
        .rd_en      (rd_en),
        .lane_empty (lane_empty),
        .lane_dout  (lane_dout),
        .rd_empty   (rd_empty),
        .rd_data    (rd_data),
        .rd_last    (rd_last),
        .lane_rd_en (lane_rd_en)
    );

endmodule

`default_nettype wire

/* bench/tb_xbridge.sv */
/*
 * Testbench for the multi-lane clock-domain bridge.
 * Runs fill, drain, mixed random traffic and a final drain with LFSR stimulus.
 * Concurrent assertions compare every read with the scoreboard and check
 * the write flags against the beat counts once the reader has been idle.
 */
`default_nettype none
`include "xbridge_macros.svh"

module tb_xbridge;
    import stream_pkg::*;

    localparam int RD_PERIOD  = 6;
    localparam int RAND_BEATS = 600;
    localparam int FULL_LEVEL = `XB_LANES * `XB_DEPTH;         // 24 beats in flight
    localparam int WATCHDOG   = ((RAND_BEATS + FULL_LEVEL) * 20 + 4 * FULL_LEVEL + 40)
                                * RD_PERIOD;

    logic  wr_clk = 1'b0;
    logic  rd_clk = 1'b0;
    logic  wr_nreset;
    logic  rd_nreset;
    data_t wr_data;
    logic  wr_last;
    logic  wr_en;
    logic  rd_en;
    logic  wr_full;
    logic  wr_almost_full;
    logic  rd_empty;
    data_t rd_data;
    logic  rd_last;

    // Scoreboard and beat counts
    beat_t       sb_q [$];                                      // Accepted but not yet read
    int          wr_total = 0;                                  // Beats written into lanes
    int          rd_total = 0;                                  // Beats popped
    int          wr_cnt [`XB_LANES] = '{default: 0};
    int          rd_cnt [`XB_LANES] = '{default: 0};
    int          wr_lane = 0;                                   // Write rotation model
    int          rd_lane = 0;
    int          rd_idle = 0;                                   // rd_clk cycles since last pop
    int          wr_target = 0;
    logic        wr_take = 1'b0;
    logic        rd_take = 1'b0;
    logic        wr_done = 1'b0;
    data_t       exp_data = '0;
    logic        exp_last = 1'b0;
    logic [15:0] lfsr = 16'd93;

    xbridge_top u_xbridge_top (
        .wr_clk         (wr_clk),
        .wr_nreset      (wr_nreset),
        .wr_data        (wr_data),
        .wr_last        (wr_last),
        .wr_en          (wr_en),
        .wr_full        (wr_full),
        .wr_almost_full (wr_almost_full),
        .rd_clk         (rd_clk),
        .rd_nreset      (rd_nreset),
        .rd_en          (rd_en),
        .rd_empty       (rd_empty),
        .rd_data        (rd_data),
        .rd_last        (rd_last)
    );

    always #2 wr_clk = ~wr_clk;                                 // Period 4
    always #3 rd_clk = ~rd_clk;                                 // Period 6

    // Galois LFSR with taps 16 14 13 11
    function automatic logic random_bit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 16'hB400;
        end
        return out;
    endfunction

    function automatic int random_bits(input int n);
        int val = 0;
        for (int k = 0; k < n; k++) begin
            val = (val << 1) | int'(random_bit());              // One step per bit
        end
        return val;
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic value_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
        abort_run($sformatf("Error %0t %s expected %0h actual %0h", $time, name, exp, act));
    endtask

    // Offer one beat or idle for the next wr_clk edge
    task automatic write_cycle(input logic want);
        @(posedge wr_clk);
        #1;
        wr_en = want && (wr_total < wr_target);                 // Stop at the beat target
        if (wr_en) begin
            wr_data = data_t'(random_bits(`XB_DATA_W));
            wr_last = random_bit();
        end
    endtask

    task automatic read_cycle(input logic want);
        @(posedge rd_clk);
        #1;
        rd_en = want;
    endtask

    // ####################################################################
    // Scoreboard sampled half a cycle before the edge that acts
    // ####################################################################

    always @(negedge wr_clk) begin
        wr_take = wr_en && !wr_full;                            // Dropped writes stay out
        if (wr_take) begin
            sb_q.push_back('{data: wr_data, last: wr_last});
        end
    end

    always @(posedge wr_clk) begin
        if (wr_take) begin
            wr_total++;
            wr_cnt[wr_lane]++;
            wr_lane = (wr_lane + 1) % `XB_LANES;
        end
    end

    always @(negedge rd_clk) begin
        rd_take = rd_en && !rd_empty;
        if (rd_take && sb_q.size() > 0) begin
            exp_data = sb_q[0].data;                            // Head due at next edge
            exp_last = sb_q[0].last;
            void'(sb_q.pop_front());
        end
    end

    always @(posedge rd_clk) begin
        if (rd_take) begin
            rd_total++;
            rd_cnt[rd_lane]++;
            rd_lane = (rd_lane + 1) % `XB_LANES;
            rd_idle = 0;
        end else if (rd_idle < 15) begin
            rd_idle++;                                          // Saturates
        end
    end

    // ####################################################################
    // Checks
    // ####################################################################

    assert property (@(posedge rd_clk) disable iff (!rd_nreset)
        (rd_en && !rd_empty) |-> rd_data == exp_data)
        else value_mismatch("rd_data", $sampled(exp_data), $sampled(rd_data));

    assert property (@(posedge rd_clk) disable iff (!rd_nreset)
        (rd_en && !rd_empty) |-> rd_last == exp_last)
        else value_mismatch("rd_last", $sampled(exp_last), $sampled(rd_last));

    // Reset values hold into the first edge after release
    assert property (@(posedge wr_clk) (!wr_nreset || $past(!wr_nreset)) |-> !wr_full)
        else value_mismatch("wr_full", 0, $sampled(wr_full));

    assert property (@(posedge wr_clk) (!wr_nreset || $past(!wr_nreset)) |-> !wr_almost_full)
        else value_mismatch("wr_almost_full", 0, $sampled(wr_almost_full));

    assert property (@(posedge rd_clk) (!rd_nreset || $past(!rd_nreset)) |-> rd_empty)
        else value_mismatch("rd_empty", 1, $sampled(rd_empty));

    assert property (@(posedge rd_clk) disable iff (!rd_nreset)
        !rd_empty |-> wr_total > rd_total)
        else abort_run("rd_empty went low while no beat was outstanding");

    // Flags are exact only after the read pointers have crossed over
    assert property (@(posedge wr_clk) disable iff (!wr_nreset)
        rd_idle >= 4 |-> wr_full == (wr_total - rd_total == FULL_LEVEL))
        else value_mismatch("wr_full", $sampled(wr_total - rd_total == FULL_LEVEL),
                            $sampled(wr_full));

    assert property (@(posedge wr_clk) disable iff (!wr_nreset)
        rd_idle >= 4 |->
            wr_almost_full == (wr_cnt[wr_lane] - rd_cnt[wr_lane] >= `XB_ALMOST_LEVEL))
        else value_mismatch("wr_almost_full",
                            $sampled(wr_cnt[wr_lane] - rd_cnt[wr_lane] >= `XB_ALMOST_LEVEL),
                            $sampled(wr_almost_full));

    initial begin
        #(WATCHDOG);
        abort_run("Watchdog expired before the traffic finished");
    end

    initial begin
        wr_nreset = 1'b1;
        rd_nreset = 1'b1;
        wr_en     = 1'b0;
        wr_data   = '0;
        wr_last   = 1'b0;
        rd_en     = 1'b0;
        #1;
        wr_nreset = 1'b0;                                       // Clean falling edge
        rd_nreset = 1'b0;
        repeat (10) @(posedge wr_clk);
        #1;
        wr_nreset = 1'b1;
        #1;
        rd_nreset = 1'b1;                                       // Clear of the rd_clk rising edge

        // Fill until back-pressure and then drain everything
        wr_target = 1 << 30;
        do begin
            write_cycle(1'b1);
        end while (!wr_full);
        write_cycle(1'b0);
        while (rd_total != wr_total) begin
            read_cycle(1'b1);
        end
        read_cycle(1'b0);

        // Mixed bursts on both sides
        wr_target = wr_total + RAND_BEATS;
        fork
            begin
                while (wr_total < wr_target) begin
                    repeat (random_bits(3) + 1) write_cycle(1'b1);
                    repeat (random_bits(2)) write_cycle(1'b0);
                end
                wr_done = 1'b1;
            end
            begin
                read_cycle(1'b0);                               // Reads start one cycle behind
                while (!wr_done) begin
                    repeat (random_bits(3) + 1) read_cycle(1'b1);
                    repeat (random_bits(3)) read_cycle(1'b0);     // Gaps up to 7 cycles
                end
            end
        join

        // Final drain where extra pops on an empty bridge are ignored
        while (rd_total != wr_total) begin
            read_cycle(1'b1);
        end
        repeat (10) read_cycle(1'b1);
        read_cycle(1'b0);
        repeat (4) @(posedge rd_clk);
        if (sb_q.size() != 0 || !rd_empty || rd_total != wr_total) begin
            abort_run($sformatf("Bridge did not drain, %0d beats left in the scoreboard",
                                sb_q.size()));
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+design
design/stream_pkg.sv
design/cdc_pkg.sv
design/lane_fifo.sv
design/lane_splitter.sv
design/lane_merger.sv
design/xbridge_top.sv
bench/tb_xbridge.sv
